/* fp_adder.f */
logic/fp_pkg.sv
logic/fp_unpack.sv
logic/fp_align_add.sv
logic/fp_round_pack.sv
logic/fp_adder.sv
sim/fp_adder_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fp_adder_tb
FILELIST = fp_adder.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/fp_adder_tests.txt */
# columns: operand a, operand b, expected z (all hex), then cycles to hold off output_z_ack
# lines starting with # are skipped
3F800000 3F800000 40000000 0
3F800000 40000000 40400000 0
40400000 BF800000 40000000 2
3FC00000 3FC00000 40400000 0
3F800000 C0000000 BF800000 1
3DCCCCCD 3E4CCCCD 3E99999A 0
4B800000 3F800000 4B800000 0
4B800001 3F800000 4B800002 3
4B800000 3FC00000 4B800001 0
4B7FFFFF 3F800000 4B800000 0
3F800000 30800000 3F800000 0
3F800000 33820000 3F800001 0
3F800000 BF7FFFFF 33800000 6
3F800000 BF800000 00000000 0
7FC00000 3F800000 FFC00000 0
3F800000 7F800001 FFC00000 8
7F800000 3F800000 7F800000 0
3F800000 FF800000 FF800000 0
00000000 40490FDB 40490FDB 0
00000000 80000000 00000000 5
80000000 80000000 80000000 0
00000001 00000001 00000002 0
00400000 00400000 00800000 0
00800000 80000001 007FFFFF 0
7F7FFFFF 7F7FFFFF 7F800000 12
7F7FFFFF 73000000 7F800000 0

/* sim/fp_adder_tb.sv */
// fp_adder testbench: file-driven operands, delayed result ack, result checks and summary
`timescale 1ns/1ps

module fp_adder_tb;
  import fp_pkg::*;

  logic     clk;
  logic     rst;
  fp_word_t input_a;
  logic     input_a_stb;
  logic     input_a_ack;
  fp_word_t input_b;
  logic     input_b_stb;
  logic     input_b_ack;
  fp_word_t output_z;
  logic     output_z_stb;
  logic     output_z_ack;

  fp_word_t op_a[$];
  fp_word_t op_b[$];
  fp_word_t exp_z[$];
  int       ack_delay[$];

  int          errors;
  int          failed;
  int          cycles;
  int          limit;
  logic [31:0] seed;
  bit          loaded;

  fp_adder fp_adder_i (
    .clk          (clk),
    .rst          (rst),
    .input_a      (input_a),
    .input_a_stb  (input_a_stb),
    .input_a_ack  (input_a_ack),
    .input_b      (input_b),
    .input_b_stb  (input_b_stb),
    .input_b_ack  (input_b_ack),
    .output_z     (output_z),
    .output_z_stb (output_z_stb),
    .output_z_ack (output_z_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // limit is known once the test file has been read
  initial begin : watchdog
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // outputs are settled 1 ns after the edge, inputs change at the same point
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic load_tests();
    int       fd;
    int       n;
    string    line;
    fp_word_t a;
    fp_word_t b;
    fp_word_t z;
    int       d;
    fd = $fopen("sim/fp_adder_tests.txt", "r");
    loaded = (fd != 0);
    if (loaded) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if ((n > 0) && (line.len() > 0) && (line[0] != "#")) begin
          if ($sscanf(line, "%h %h %h %d", a, b, z, d) == 4) begin
            op_a.push_back(a);
            op_b.push_back(b);
            exp_z.push_back(z);
            ack_delay.push_back(d);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_reset_state();
    assert (!output_z_stb && !input_b_ack) else begin
      $display("output_z_stb or input_b_ack is high right after reset");
      errors++;
    end
    while (!input_a_ack) begin
      tick();
      assert (!output_z_stb) else begin
        $display("a result appeared before input_a_ack was raised");
        errors++;
      end
    end
  endtask

  task automatic send_a(input fp_word_t v);
    input_a     = v;
    input_a_stb = 1'b1;
    while (!input_a_ack) tick();
    tick();
    input_a_stb = 1'b0;
  endtask

  task automatic send_b(input fp_word_t v);
    input_b     = v;
    input_b_stb = 1'b1;
    while (!input_b_ack) tick();
    tick();
    input_b_stb = 1'b0;
  endtask

  task automatic run_test(input int idx);
    fp_word_t held;
    int       bad;
    bad = 0;
    send_a(op_a[idx]);
    send_b(op_b[idx]);
    while (!output_z_stb) tick();
    held = output_z;
    assert (output_z == exp_z[idx]) else begin
      $display("MISMATCH output_z: got %h expected %h", output_z, exp_z[idx]);
      bad++;
    end
    // consumer stalls, result and front end must both hold
    repeat (ack_delay[idx]) begin
      tick();
      assert (output_z_stb) else begin
        $display("output_z_stb dropped before output_z_ack was given");
        bad++;
      end
      assert (output_z == held) else begin
        $display("MISMATCH output_z: held %h now %h", held, output_z);
        bad++;
      end
      assert (!input_a_ack) else begin
        $display("input_a_ack rose while the result was still waiting for ack");
        bad++;
      end
    end
    output_z_ack = 1'b1;
    tick();
    output_z_ack = 1'b0;
    $display("test %0d: %h + %h -> %h, expected %h, %s", idx, op_a[idx], op_b[idx],
             held, exp_z[idx], (bad == 0) ? "ok" : "failed");
    if (bad != 0) begin
      failed++;
    end
    errors += bad;
  endtask

  initial begin
    int idle;
    rst          = 1'b1;
    input_a      = '0;
    input_a_stb  = 1'b0;
    input_b      = '0;
    input_b_stb  = 1'b0;
    output_z_ack = 1'b0;
    errors       = 0;
    failed       = 0;
    cycles       = 0;
    limit        = 0;
    seed         = 32'd82;
    load_tests();
    if (loaded) begin
      limit = op_a.size() * 80 + 100;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    check_reset_state();
    if (!loaded || (op_a.size() == 0)) begin
      $display("no tests could be read from sim/fp_adder_tests.txt");
      errors++;
    end
    for (int i = 0; i < op_a.size(); i++) begin
      run_test(i);
      seed = lcg_next(seed);
      idle = int'((seed >> 16) % 4);
      repeat (idle) tick();
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             op_a.size(), op_a.size() - failed, failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* logic/fp_adder.sv */
// fp_adder: single-precision floating-point adder with strobe/ack operand and result ports
`timescale 1ns/1ps

module fp_adder (
  input  logic              clk,
  input  logic              rst,
  input  fp_pkg::fp_word_t  input_a,
  input  logic              input_a_stb,
  output logic              input_a_ack,
  input  fp_pkg::fp_word_t  input_b,
  input  logic              input_b_stb,
  output logic              input_b_ack,
  output fp_pkg::fp_word_t  output_z,
  output logic              output_z_stb,
  input  logic              output_z_ack
);
  import fp_pkg::*;

  logic     spec_valid;
  fp_word_t spec_z;
  logic     ops_valid;
  logic     a_s;
  logic     b_s;
  fp_exp_t  a_e;
  fp_exp_t  b_e;
  add_sig_t a_m;
  add_sig_t b_m;
  logic     sum_valid;
  logic     sum_s;
  fp_exp_t  sum_e;
  fp_sig_t  sum_m;
  logic     sum_guard;
  logic     sum_round;
  logic     sum_sticky;
  logic     res_done;

  fp_unpack unpack_i (
    .clk         (clk),
    .rst         (rst),
    .input_a     (input_a),
    .input_a_stb (input_a_stb),
    .input_a_ack (input_a_ack),
    .input_b     (input_b),
    .input_b_stb (input_b_stb),
    .input_b_ack (input_b_ack),
    .res_done    (res_done),
    .spec_valid  (spec_valid),
    .spec_z      (spec_z),
    .ops_valid   (ops_valid),
    .a_s         (a_s),
    .b_s         (b_s),
    .a_e         (a_e),
    .b_e         (b_e),
    .a_m         (a_m),
    .b_m         (b_m)
  );

  fp_align_add align_add_i (
    .clk        (clk),
    .rst        (rst),
    .ops_valid  (ops_valid),
    .a_s        (a_s),
    .b_s        (b_s),
    .a_e        (a_e),
    .b_e        (b_e),
    .a_m        (a_m),
    .b_m        (b_m),
    .sum_valid  (sum_valid),
    .sum_s      (sum_s),
    .sum_e      (sum_e),
    .sum_m      (sum_m),
    .sum_guard  (sum_guard),
    .sum_round  (sum_round),
    .sum_sticky (sum_sticky)
  );

  fp_round_pack round_pack_i (
    .clk          (clk),
    .rst          (rst),
    .spec_valid   (spec_valid),
    .spec_z       (spec_z),
    .sum_valid    (sum_valid),
    .sum_s        (sum_s),
    .sum_e        (sum_e),
    .sum_m        (sum_m),
    .sum_guard    (sum_guard),
    .sum_round    (sum_round),
    .sum_sticky   (sum_sticky),
    .output_z     (output_z),
    .output_z_stb (output_z_stb),
    .output_z_ack (output_z_ack),
    .res_done     (res_done)
  );

endmodule

/* logic/fp_round_pack.sv */
// fp_round_pack: normalisation, round to nearest even, packing and result handshake
`timescale 1ns/1ps

module fp_round_pack (
  input  logic              clk,
  input  logic              rst,
  input  logic              spec_valid,
  input  fp_pkg::fp_word_t  spec_z,
  input  logic              sum_valid,
  input  logic              sum_s,
  input  fp_pkg::fp_exp_t   sum_e,
  input  fp_pkg::fp_sig_t   sum_m,
  input  logic              sum_guard,
  input  logic              sum_round,
  input  logic              sum_sticky,
  output fp_pkg::fp_word_t  output_z,
  output logic              output_z_stb,
  input  logic              output_z_ack,
  output logic              res_done
);
  import fp_pkg::*;

  typedef enum logic [2:0] {
    rp_idle,
    rp_norm_left,
    rp_norm_right,
    rp_round,
    rp_pack,
    rp_hold
  } rp_state_t;

  rp_state_t state;

  logic    z_s;
  fp_exp_t z_e;
  fp_sig_t z_m;
  logic    guard;
  logic    round_bit;
  logic    sticky;
  fp_exp_t z_e_biased;

  assign z_e_biased = z_e + exp_bias;

  // frees the front end on the same edge the result is taken
  assign res_done = output_z_stb && output_z_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= rp_idle;
      output_z_stb <= 1'b0;
    end else begin
      case (state)
        rp_idle: begin
          if (spec_valid) begin
            output_z     <= spec_z;
            output_z_stb <= 1'b1;
            state        <= rp_hold;
          end else if (sum_valid) begin
            z_s       <= sum_s;
            z_e       <= sum_e;
            z_m       <= sum_m;
            guard     <= sum_guard;
            round_bit <= sum_round;
            sticky    <= sum_sticky;
            state     <= rp_norm_left;
          end
        end
        rp_norm_left: begin
          // stops at the denormal exponent even if the hidden bit is still clear
          if (!z_m[23] && (z_e > exp_min)) begin
            z_e       <= z_e - 10'sd1;
            z_m       <= {z_m[22:0], guard};
            guard     <= round_bit;
            round_bit <= 1'b0;
          end else begin
            state <= rp_norm_right;
          end
        end
        rp_norm_right: begin
          if (z_e < exp_min) begin
            z_e       <= z_e + 10'sd1;
            z_m       <= {1'b0, z_m[23:1]};
            guard     <= z_m[0];
            round_bit <= guard;
            sticky    <= sticky | round_bit;
          end else begin
            state <= rp_round;
          end
        end
        rp_round: begin
          // ties go to the even significand
          if (guard && (round_bit || sticky || z_m[0])) begin
            z_m <= z_m + 24'd1;
            if (&z_m) begin
              z_e <= z_e + 10'sd1;
            end
          end
          state <= rp_pack;
        end
        rp_pack: begin
          if (z_e > exp_bias) begin
            output_z <= {z_s, exp_all_ones, 23'd0};
          end else if ((z_e == exp_min) && !z_m[23]) begin
            output_z <= {z_s, 8'd0, z_m[22:0]};
          end else begin
            output_z <= {z_s, z_e_biased[7:0], z_m[22:0]};
          end
          output_z_stb <= 1'b1;
          state        <= rp_hold;
        end
        rp_hold: begin
          if (output_z_ack) begin
            output_z_stb <= 1'b0;
            state        <= rp_idle;
          end
        end
        default: state <= rp_idle;
      endcase
    end
  end

  // result must not move or vanish while the consumer is stalling
  z_held_under_stall: assert property (
    @(posedge clk) disable iff (rst)
    output_z_stb && !output_z_ack |=> output_z_stb && $stable(output_z)
  );

endmodule

/* logic/fp_align_add.sv */
// fp_align_add: exponent alignment with sticky, significand add/subtract and carry split
`timescale 1ns/1ps

module fp_align_add (
  input  logic              clk,
  input  logic              rst,
  input  logic              ops_valid,
  input  logic              a_s,
  input  logic              b_s,
  input  fp_pkg::fp_exp_t   a_e,
  input  fp_pkg::fp_exp_t   b_e,
  input  fp_pkg::add_sig_t  a_m,
  input  fp_pkg::add_sig_t  b_m,
  output logic              sum_valid,
  output logic              sum_s,
  output fp_pkg::fp_exp_t   sum_e,
  output fp_pkg::fp_sig_t   sum_m,
  output logic              sum_guard,
  output logic              sum_round,
  output logic              sum_sticky
);
  import fp_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_align,
    st_add,
    st_split
  } align_state_t;

  align_state_t state;

  logic     op_a_s;
  logic     op_b_s;
  fp_exp_t  op_a_e;
  fp_exp_t  op_b_e;
  add_sig_t op_a_m;
  add_sig_t op_b_m;
  add_sum_t sum_raw;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (ops_valid) begin
            op_a_s <= a_s;
            op_b_s <= b_s;
            op_a_e <= a_e;
            op_b_e <= b_e;
            op_a_m <= a_m;
            op_b_m <= b_m;
            state  <= st_align;
          end
        end
        st_align: begin
          // one place per cycle, bits shifted out fold into the sticky bit
          if (op_a_e > op_b_e) begin
            op_b_e <= op_b_e + 10'sd1;
            op_b_m <= {1'b0, op_b_m[26:2], op_b_m[1] | op_b_m[0]};
          end else if (op_a_e < op_b_e) begin
            op_a_e <= op_a_e + 10'sd1;
            op_a_m <= {1'b0, op_a_m[26:2], op_a_m[1] | op_a_m[0]};
          end else begin
            state <= st_add;
          end
        end
        st_add: begin
          sum_e <= op_a_e;
          if (op_a_s == op_b_s) begin
            sum_raw <= {1'b0, op_a_m} + {1'b0, op_b_m};
            sum_s   <= op_a_s;
          end else if (op_a_m >= op_b_m) begin
            sum_raw <= {1'b0, op_a_m} - {1'b0, op_b_m};
            // exact cancellation gives +0
            sum_s   <= op_a_s && (op_a_m != op_b_m);
          end else begin
            sum_raw <= {1'b0, op_b_m} - {1'b0, op_a_m};
            sum_s   <= op_b_s;
          end
          state <= st_split;
        end
        st_split: begin
          if (sum_raw[27]) begin
            sum_m      <= sum_raw[27:4];
            sum_guard  <= sum_raw[3];
            sum_round  <= sum_raw[2];
            sum_sticky <= sum_raw[1] | sum_raw[0];
            sum_e      <= sum_e + 10'sd1;
          end else begin
            sum_m      <= sum_raw[26:3];
            sum_guard  <= sum_raw[2];
            sum_round  <= sum_raw[1];
            sum_sticky <= sum_raw[0];
          end
          sum_valid <= 1'b1;
          state     <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // the front end holds off a new operation until this one has drained
  ops_while_idle: assert property (
    @(posedge clk) disable iff (rst) ops_valid |-> state == st_idle
  );

endmodule

/* logic/fp_unpack.sv */
// fp_unpack: operand handshake, field unpacking and special-operand classification
`timescale 1ns/1ps

module fp_unpack (
  input  logic              clk,
  input  logic              rst,
  input  fp_pkg::fp_word_t  input_a,
  input  logic              input_a_stb,
  output logic              input_a_ack,
  input  fp_pkg::fp_word_t  input_b,
  input  logic              input_b_stb,
  output logic              input_b_ack,
  input  logic              res_done,
  output logic              spec_valid,
  output fp_pkg::fp_word_t  spec_z,
  output logic              ops_valid,
  output logic              a_s,
  output logic              b_s,
  output fp_pkg::fp_exp_t   a_e,
  output fp_pkg::fp_exp_t   b_e,
  output fp_pkg::add_sig_t  a_m,
  output fp_pkg::add_sig_t  b_m
);
  import fp_pkg::*;

  front_state_t state;
  fp_word_t     a_word;
  fp_word_t     b_word;

  logic a_nan;
  logic b_nan;
  logic a_inf;
  logic b_inf;
  logic a_zero;
  logic b_zero;
  logic spec_case;

  // classification of the unpacked fields, fraction still without hidden bit
  assign a_nan  = (a_e == exp_special) && (a_m != '0);
  assign b_nan  = (b_e == exp_special) && (b_m != '0);
  assign a_inf  = (a_e == exp_special);
  assign b_inf  = (b_e == exp_special);
  assign a_zero = (a_e == exp_zero_den) && (a_m == '0);
  assign b_zero = (b_e == exp_zero_den) && (b_m == '0);
  assign spec_case = a_inf || b_inf || a_zero || b_zero;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= get_a;
      input_a_ack <= 1'b0;
      input_b_ack <= 1'b0;
      spec_valid  <= 1'b0;
      ops_valid   <= 1'b0;
    end else begin
      spec_valid <= 1'b0;
      ops_valid  <= 1'b0;
      case (state)
        get_a: begin
          input_a_ack <= 1'b1;
          if (input_a_ack && input_a_stb) begin
            a_word      <= input_a;
            input_a_ack <= 1'b0;
            state       <= get_b;
          end
        end
        get_b: begin
          input_b_ack <= 1'b1;
          if (input_b_ack && input_b_stb) begin
            b_word      <= input_b;
            input_b_ack <= 1'b0;
            state       <= unpack;
          end
        end
        unpack: begin
          a_s   <= a_word[31];
          b_s   <= b_word[31];
          a_e   <= $signed({2'b00, a_word[30:23]}) - exp_bias;
          b_e   <= $signed({2'b00, b_word[30:23]}) - exp_bias;
          a_m   <= {1'b0, a_word[22:0], 3'b000};
          b_m   <= {1'b0, b_word[22:0], 3'b000};
          state <= classify;
        end
        classify: begin
          // NaN first, then infinities, then zeros
          if (a_nan || b_nan) begin
            spec_z <= qnan_word;
          end else if (a_inf) begin
            spec_z <= {a_s, exp_all_ones, 23'd0};
          end else if (b_inf) begin
            spec_z <= {b_s, exp_all_ones, 23'd0};
          end else if (a_zero && b_zero) begin
            spec_z <= {a_s & b_s, 31'd0};
          end else if (a_zero) begin
            spec_z <= b_word;
          end else begin
            spec_z <= a_word;
          end
          // denormals keep a clear hidden bit at the minimum exponent
          if (a_e == exp_zero_den) begin
            a_e <= exp_min;
          end else begin
            a_m[26] <= 1'b1;
          end
          if (b_e == exp_zero_den) begin
            b_e <= exp_min;
          end else begin
            b_m[26] <= 1'b1;
          end
          spec_valid <= spec_case;
          ops_valid  <= !spec_case;
          state      <= busy;
        end
        busy: begin
          if (res_done) begin
            state <= get_a;
          end
        end
        default: state <= get_a;
      endcase
    end
  end

  // only one operand port is open at a time
  a_b_ack_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(input_a_ack && input_b_ack)
  );

endmodule

/* logic/fp_pkg.sv */
// fp_pkg: IEEE-754 single-precision types, field constants and front-end states
package fp_pkg;

  // packed single-precision value, sign / exponent / fraction
  typedef logic [31:0] fp_word_t;

  // unbiased exponent, two bits of headroom above the 8-bit field
  typedef logic signed [9:0] fp_exp_t;

  // significand including the hidden bit
  typedef logic [23:0] fp_sig_t;

  // hidden bit, 23 fraction bits, then guard, round and sticky
  typedef logic [26:0] add_sig_t;

  // alignment significand plus carry-out
  typedef logic [27:0] add_sum_t;

  // operand capture and classification sequence
  typedef enum logic [2:0] {
    get_a,
    get_b,
    unpack,
    classify,
    busy
  } front_state_t;

  localparam fp_exp_t exp_bias = 10'sd127;

  // biased 255, infinity or NaN
  localparam fp_exp_t exp_special = 10'sd128;

  // biased 0, zero or denormal
  localparam fp_exp_t exp_zero_den = -10'sd127;

  // denormals live at this exponent
  localparam fp_exp_t exp_min = -10'sd126;

  localparam fp_word_t qnan_word = 32'hFFC0_0000;

  localparam logic [7:0] exp_all_ones = 8'd255;

endpackage
